// ==== hw/fp_pkg.sv ====
package fp_pkg;

    // single-precision field widths
    localparam int EXP_W = 8;
    localparam int MAN_W = 23;
    localparam int SIG_W = MAN_W + 1;

    typedef logic [EXP_W-1:0] exp_t;
    typedef logic [MAN_W-1:0] man_t;

    // significand with the hidden one on top
    typedef logic [SIG_W-1:0] sig_t;

    typedef struct packed {
        logic sign;
        exp_t exp;
        man_t man;
    } float_t;

    typedef enum logic {
        FADD_ADD = 1'b0,
        FADD_SUB = 1'b1
    } fadd_op_t;

endpackage

// ==== hw/fadd_pkg.sv ====
package fadd_pkg;

    import fp_pkg::*;

    // guard, round and sticky kept below the aligned far operand
    localparam int GRS_W = 3;

    typedef logic [SIG_W+GRS_W-1:0] far_sig_t;

    // close path works one bit below the hidden position
    typedef logic [SIG_W:0] close_diff_t;
    typedef logic [4:0] shamt_t;

    // man holds hidden bit, 23 mantissa bits and the guard bit
    typedef struct packed {
        logic sign;
        exp_t exp;
        logic [SIG_W:0] man;
        logic sticky;
    } pre_res_t;

endpackage

// ==== hw/lzc.sv ====
`timescale 1ns/1ps

module lzc import fadd_pkg::*; (
    input  close_diff_t x,
    output shamt_t      cnt
);

    localparam int N = $bits(close_diff_t);

    // highest set bit wins, so scan upwards and let later hits override
    always_comb begin
        cnt = shamt_t'(N);
        for (int i = 0; i < N; i++) begin
            if (x[i]) begin
                cnt = shamt_t'(N - 1 - i);
            end
        end
    end

endmodule

// ==== hw/fadd_align.sv ====
`timescale 1ns/1ps

module fadd_align import fp_pkg::*, fadd_pkg::*; #(
    parameter int TAG_W = 5
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  fadd_op_t         op,
    input  float_t           x,
    input  float_t           y,
    input  logic [TAG_W-1:0] in_tag,
    output logic             s1_valid,
    output logic [TAG_W-1:0] s1_tag,
    output logic             s1_is_add,
    output logic             s1_is_close,
    output logic             s1_sign,
    output exp_t             s1_big_exp,
    output sig_t             s1_big_sig,
    output far_sig_t         s1_small_far,
    output close_diff_t      s1_diff,
    output logic             s1_diff_neg,
    output logic             s1_swap_neg
);

    // past this gap every small-operand bit ends up in sticky
    localparam int SAT_GAP = SIG_W + 2;
    localparam int WIDE_W  = SIG_W + SAT_GAP;

    logic              y_sign;
    logic              x_big;
    logic              is_add;
    logic              is_close;
    exp_t              big_exp;
    exp_t              small_exp;
    exp_t              gap;
    sig_t              big_sig;
    sig_t              small_sig;
    logic [WIDE_W-1:0] small_wide;
    far_sig_t          small_far;
    close_diff_t       small_close;
    logic [SIG_W+1:0]  diff_fwd;
    logic [SIG_W+1:0]  diff_rev;
    close_diff_t       diff_abs;

    always_comb begin
        y_sign    = y.sign ^ (op == FADD_SUB);
        x_big     = x.exp >= y.exp;
        big_exp   = x_big ? x.exp : y.exp;
        small_exp = x_big ? y.exp : x.exp;
        gap       = big_exp - small_exp;
        big_sig   = x_big ? {1'b1, x.man} : {1'b1, y.man};
        small_sig = x_big ? {1'b1, y.man} : {1'b1, x.man};
        is_add    = ~(x.sign ^ y_sign);
        is_close  = ~is_add & (gap <= exp_t'(1));

        // far alignment with sticky collapse
        if (gap >= exp_t'(SAT_GAP)) begin
            small_wide = {{SAT_GAP{1'b0}}, small_sig};
        end else begin
            small_wide = {small_sig, {SAT_GAP{1'b0}}} >> gap;
        end
        small_far = {small_wide[WIDE_W-1 -: SAT_GAP], |small_wide[SIG_W-1:0]};

        // close path: gap is 0 or 1, so one spare bit keeps it exact
        small_close = {small_sig, 1'b0} >> gap[0];
        diff_fwd    = {1'b0, big_sig, 1'b0} - {1'b0, small_close};
        diff_rev    = {1'b0, small_close} - {1'b0, big_sig, 1'b0};
        diff_abs    = diff_fwd[SIG_W+1] ? diff_rev[SIG_W:0] : diff_fwd[SIG_W:0];
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            s1_valid     <= 1'b0;
            s1_tag       <= '0;
            s1_is_add    <= 1'b0;
            s1_is_close  <= 1'b0;
            s1_sign      <= 1'b0;
            s1_big_exp   <= '0;
            s1_big_sig   <= '0;
            s1_small_far <= '0;
            s1_diff      <= '0;
            s1_diff_neg  <= 1'b0;
            s1_swap_neg  <= 1'b0;
        end else begin
            s1_valid     <= in_valid;
            s1_tag       <= in_tag;
            s1_is_add    <= is_add;
            s1_is_close  <= is_close;
            s1_sign      <= x_big ? x.sign : y_sign;
            s1_big_exp   <= big_exp;
            s1_big_sig   <= big_sig;
            s1_small_far <= small_far;
            s1_diff      <= diff_abs;
            s1_diff_neg  <= diff_fwd[SIG_W+1];
            s1_swap_neg  <= diff_rev[SIG_W+1];
        end
    end

endmodule

// ==== hw/fadd_far_path.sv ====
`timescale 1ns/1ps

module fadd_far_path import fp_pkg::*, fadd_pkg::*; (
    input  logic     s1_is_add,
    input  logic     s1_sign,
    input  exp_t     s1_big_exp,
    input  sig_t     s1_big_sig,
    input  far_sig_t s1_small_far,
    output pre_res_t far_res
);

    localparam int SUM_W = SIG_W + GRS_W + 1;

    logic [SUM_W-1:0] big_ext;
    logic [SUM_W-1:0] sum;
    logic [SIG_W:0]   man;
    logic             sticky;
    logic [9:0]       e_adj;
    logic             udf;
    logic             ovf;

    always_comb begin
        big_ext = {1'b0, s1_big_sig, {GRS_W{1'b0}}};
        sum = s1_is_add ? big_ext + {1'b0, s1_small_far} : big_ext - {1'b0, s1_small_far};

        // at most one position of shift either way on this path
        if (sum[SUM_W-1]) begin
            man    = sum[SUM_W-1 -: SIG_W+1];
            sticky = |sum[GRS_W-1:0];
            e_adj  = {2'b0, s1_big_exp} + 10'd1;
        end else if (sum[SUM_W-2]) begin
            man    = sum[SUM_W-2 -: SIG_W+1];
            sticky = |sum[GRS_W-2:0];
            e_adj  = {2'b0, s1_big_exp};
        end else begin
            man    = sum[SUM_W-3 -: SIG_W+1];
            sticky = sum[0];
            e_adj  = {2'b0, s1_big_exp} - 10'd1;
        end

        udf = e_adj[9] | (e_adj == 10'd0);
        ovf = ~e_adj[9] & (e_adj[8:0] >= 9'd255);

        far_res.sign   = udf ? 1'b0 : s1_sign;
        far_res.exp    = udf ? '0 : (ovf ? '1 : e_adj[7:0]);
        far_res.man    = (udf | ovf) ? '0 : man;
        far_res.sticky = (udf | ovf) ? 1'b0 : sticky;
    end

endmodule

// ==== hw/fadd_close_path.sv ====
`timescale 1ns/1ps

module fadd_close_path import fp_pkg::*, fadd_pkg::*; (
    input  logic        s1_sign,
    input  exp_t        s1_big_exp,
    input  close_diff_t s1_diff,
    input  logic        s1_diff_neg,
    input  logic        s1_swap_neg,
    output pre_res_t    close_res
);

    shamt_t     lz;
    logic [8:0] e_sub;
    logic       zero;

    lzc u_lzc (
        .x   (s1_diff),
        .cnt (lz)
    );

    always_comb begin
        // bit 8 acts as the sign, the count never exceeds 25
        e_sub = {1'b0, s1_big_exp} - {4'b0, lz};
        zero  = e_sub[8] | (e_sub == 9'd0) | (s1_diff == '0);

        if (zero) begin
            close_res.sign = 1'b0;
        end else if (s1_diff_neg) begin
            close_res.sign = ~s1_sign;
        end else begin
            close_res.sign = s1_swap_neg & s1_sign;
        end

        close_res.exp    = zero ? '0 : e_sub[7:0];
        close_res.man    = zero ? '0 : s1_diff << lz;
        // the difference is exact here
        close_res.sticky = 1'b0;
    end

endmodule

// ==== hw/fadd_round.sv ====
`timescale 1ns/1ps

module fadd_round import fp_pkg::*, fadd_pkg::*; #(
    parameter int TAG_W = 5
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             s1_valid,
    input  logic [TAG_W-1:0] s1_tag,
    input  logic             s1_is_close,
    input  pre_res_t         far_res,
    input  pre_res_t         close_res,
    output float_t           res,
    output logic             res_valid,
    output logic [TAG_W-1:0] res_tag
);

    pre_res_t     pre;
    logic         round_up;
    logic [SIG_W:0] rounded;
    exp_t         exp_out;
    man_t         man_out;

    always_comb begin
        pre = s1_is_close ? close_res : far_res;

        // guard set and either sticky or an odd lsb
        round_up = pre.man[0] & (pre.sticky | pre.man[1]);
        rounded  = {1'b0, pre.man[SIG_W:1]} + {{SIG_W{1'b0}}, round_up};

        // carry past the hidden bit leaves zeros in the mantissa
        if (rounded[SIG_W]) begin
            exp_out = pre.exp + exp_t'(1);
            man_out = '0;
        end else begin
            exp_out = pre.exp;
            man_out = rounded[MAN_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            res       <= '0;
            res_valid <= 1'b0;
            res_tag   <= '0;
        end else begin
            res       <= {pre.sign, exp_out, man_out};
            res_valid <= s1_valid;
            res_tag   <= s1_tag;
        end
    end

endmodule

// ==== hw/fpu_add_unit.sv ====
`timescale 1ns/1ps

module fpu_add_unit import fp_pkg::*, fadd_pkg::*; #(
    parameter int TAG_W = 5
) (
    input  logic             clk,
    input  logic             rstn,
    input  logic             in_valid,
    input  fadd_op_t         op,
    input  float_t           x,
    input  float_t           y,
    input  logic [TAG_W-1:0] in_tag,
    output float_t           res,
    output logic             res_valid,
    output logic [TAG_W-1:0] res_tag
);

    logic             s1_valid;
    logic [TAG_W-1:0] s1_tag;
    logic             s1_is_add;
    logic             s1_is_close;
    logic             s1_sign;
    exp_t             s1_big_exp;
    sig_t             s1_big_sig;
    far_sig_t         s1_small_far;
    close_diff_t      s1_diff;
    logic             s1_diff_neg;
    logic             s1_swap_neg;
    pre_res_t         far_res;
    pre_res_t         close_res;

    fadd_align #(
        .TAG_W (TAG_W)
    ) u_align (
        .clk          (clk),
        .rstn         (rstn),
        .in_valid     (in_valid),
        .op           (op),
        .x            (x),
        .y            (y),
        .in_tag       (in_tag),
        .s1_valid     (s1_valid),
        .s1_tag       (s1_tag),
        .s1_is_add    (s1_is_add),
        .s1_is_close  (s1_is_close),
        .s1_sign      (s1_sign),
        .s1_big_exp   (s1_big_exp),
        .s1_big_sig   (s1_big_sig),
        .s1_small_far (s1_small_far),
        .s1_diff      (s1_diff),
        .s1_diff_neg  (s1_diff_neg),
        .s1_swap_neg  (s1_swap_neg)
    );

    fadd_far_path u_far_path (
        .s1_is_add    (s1_is_add),
        .s1_sign      (s1_sign),
        .s1_big_exp   (s1_big_exp),
        .s1_big_sig   (s1_big_sig),
        .s1_small_far (s1_small_far),
        .far_res      (far_res)
    );

    fadd_close_path u_close_path (
        .s1_sign     (s1_sign),
        .s1_big_exp  (s1_big_exp),
        .s1_diff     (s1_diff),
        .s1_diff_neg (s1_diff_neg),
        .s1_swap_neg (s1_swap_neg),
        .close_res   (close_res)
    );

    fadd_round #(
        .TAG_W (TAG_W)
    ) u_round (
        .clk         (clk),
        .rstn        (rstn),
        .s1_valid    (s1_valid),
        .s1_tag      (s1_tag),
        .s1_is_close (s1_is_close),
        .far_res     (far_res),
        .close_res   (close_res),
        .res         (res),
        .res_valid   (res_valid),
        .res_tag     (res_tag)
    );

endmodule

// ==== test/tb_fpu_add_unit.sv ====
`timescale 1ns/1ps

module tb_fpu_add_unit import fp_pkg::*; ();

    localparam int TAG_W = 5;

    logic             clk;
    logic             rstn;
    logic             in_valid;
    fadd_op_t         op;
    float_t           x;
    float_t           y;
    logic [TAG_W-1:0] in_tag;
    float_t           res;
    logic             res_valid;
    logic [TAG_W-1:0] res_tag;

    logic [31:0]      lfsr_state = 32'd23;
    int               cycle = 0;
    logic [TAG_W-1:0] next_tag = '0;

    // scoreboard, one entry per issued operation
    float_t           exp_q[$];
    logic [TAG_W-1:0] tag_q[$];
    int               due_q[$];
    string            name_q[$];

    fpu_add_unit #(
        .TAG_W (TAG_W)
    ) u_fpu_add_unit (
        .clk       (clk),
        .rstn      (rstn),
        .in_valid  (in_valid),
        .op        (op),
        .x         (x),
        .y         (y),
        .in_tag    (in_tag),
        .res       (res),
        .res_valid (res_valid),
        .res_tag   (res_tag)
    );

    always #5 clk = ~clk;

    // 32-bit fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic int random_exp();
        return 64 + int'(take_bits(7)) % 127;
    endfunction

    function automatic float_t make_float(input logic s, input int e, input man_t m);
        return {s, exp_t'(e), m};
    endfunction

    // exact sum of the aligned integers, then round to nearest even
    function automatic float_t expected_sum(input float_t a, input float_t b, input fadd_op_t o);
        logic [159:0] ma;
        logic [159:0] mb;
        logic [159:0] mag;
        logic [159:0] rem;
        logic [159:0] half;
        logic [159:0] one;
        logic [23:0]  sig;
        logic [24:0]  sig_r;
        logic         sb;
        logic         s;
        logic         up;
        int           ea;
        int           eb;
        int           emin;
        int           p;
        int           sh;
        int           e;
        one  = 160'd1;
        sb   = b.sign ^ (o == FADD_SUB);
        ea   = int'(a.exp);
        eb   = int'(b.exp);
        emin = (ea < eb) ? ea : eb;
        ma   = {136'd0, 1'b1, a.man} << (ea - emin);
        mb   = {136'd0, 1'b1, b.man} << (eb - emin);
        if (a.sign == sb) begin
            mag = ma + mb;
            s   = a.sign;
        end else if (ma >= mb) begin
            mag = ma - mb;
            s   = a.sign;
        end else begin
            mag = mb - ma;
            s   = sb;
        end
        if (mag == '0) begin
            return '0;
        end
        p = 0;
        for (int i = 0; i < 160; i++) begin
            if (mag[i]) begin
                p = i;
            end
        end
        up = 1'b0;
        if (p <= 23) begin
            sig = mag[23:0] << (23 - p);
        end else begin
            sh   = p - 23;
            rem  = mag & ((one << sh) - one);
            half = one << (sh - 1);
            sig  = 24'(mag >> sh);
            up   = (rem > half) || (rem == half && sig[0]);
        end
        sig_r = {1'b0, sig} + {24'd0, up};
        e = emin + p - 23;
        if (sig_r[24]) begin
            return make_float(s, e + 1, '0);
        end
        return make_float(s, e, sig_r[22:0]);
    endfunction

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation finished: FAIL");
        $fatal(1);
    endtask

    task automatic check_float(input string name, input float_t expected, input float_t actual);
        if (expected !== actual) begin
            report_failure($sformatf("Mismatch in %s: expected %h, actual %h",
                                     name, expected, actual));
        end
    endtask

    task automatic check_tag(input string name, input logic [TAG_W-1:0] expected,
                             input logic [TAG_W-1:0] actual);
        if (expected !== actual) begin
            report_failure($sformatf("Mismatch in %s tag: expected %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    task automatic check_cycle(input string name, input int expected, input int actual);
        if (expected != actual) begin
            report_failure($sformatf("Mismatch in %s latency: expected cycle %0d, actual %0d",
                                     name, expected, actual));
        end
    endtask

    // issued at edge k, taken by the DUT at k+1, seen here at k+3
    // the first edge only applies the reset
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle > 0 && res_valid !== 1'b0) begin
            if (exp_q.size() == 0) begin
                report_failure("result valid while no operation was pending");
            end else begin
                check_float(name_q[0], exp_q[0], res);
                check_tag(name_q[0], tag_q[0], res_tag);
                check_cycle(name_q[0], due_q[0], cycle);
                void'(exp_q.pop_front());
                void'(tag_q.pop_front());
                void'(due_q.pop_front());
                void'(name_q.pop_front());
            end
        end
    end

    task automatic issue(input string name, input fadd_op_t o, input float_t a, input float_t b);
        @(posedge clk);
        in_valid <= 1'b1;
        op       <= o;
        x        <= a;
        y        <= b;
        in_tag   <= next_tag;
        exp_q.push_back(expected_sum(a, b, o));
        tag_q.push_back(next_tag);
        due_q.push_back(cycle + 3);
        name_q.push_back(name);
        next_tag = next_tag + 1'b1;
        // sometimes leave a bubble
        if (take_bits(2) == 0) begin
            @(posedge clk);
            in_valid <= 1'b0;
        end
    endtask

    task automatic run_far(input int n);
        float_t a;
        float_t b;
        int     ea;
        for (int i = 0; i < n; i++) begin
            ea = random_exp();
            a  = make_float(1'(take_bits(1)), ea, man_t'(take_bits(23)));
            if (take_bits(1) == 1 && ea >= 121) begin
                // gap of 26 or more
                b = make_float(1'(take_bits(1)), ea - 26 - int'(take_bits(5)),
                               man_t'(take_bits(23)));
            end else begin
                b = make_float(1'(take_bits(1)), random_exp(), man_t'(take_bits(23)));
            end
            issue("far path", fadd_op_t'(take_bits(1)), a, b);
        end
    endtask

    task automatic run_close(input int n);
        float_t a;
        float_t b;
        int     ea;
        logic   s;
        for (int i = 0; i < n; i++) begin
            ea = 65 + int'(take_bits(7)) % 125;
            s  = 1'(take_bits(1));
            a  = make_float(s, ea, man_t'(take_bits(23)));
            b  = make_float(s, ea - 1 + int'(take_bits(2)) % 3, man_t'(take_bits(23)));
            issue("close path", FADD_SUB, a, b);
            // heavy cancellation, only low mantissa bits differ
            b = make_float(~s, ea, a.man ^ man_t'(take_bits(6)));
            issue("cancellation", FADD_ADD, a, b);
            issue("x minus x", FADD_SUB, a, a);
        end
    endtask

    task automatic run_rounding(input int n);
        float_t a;
        float_t b;
        int     ea;
        for (int i = 0; i < n; i++) begin
            ea = 90 + int'(take_bits(6));
            // b is exactly half an ulp of a
            a = make_float(1'b0, ea, man_t'(take_bits(23)));
            b = make_float(1'b0, ea - 24, '0);
            issue("halfway tie", FADD_ADD, a, b);
            a = make_float(1'b0, ea, '1);
            b = make_float(1'b0, ea - 23 - int'(take_bits(1)), man_t'(take_bits(23)));
            issue("mantissa carry", FADD_ADD, a, b);
        end
    endtask

    task automatic wait_drain();
        @(posedge clk);
        in_valid <= 1'b0;
        for (int i = 0; i < 20 && exp_q.size() > 0; i++) begin
            @(posedge clk);
        end
        if (exp_q.size() > 0) begin
            report_failure("timed out waiting for pending results");
        end
    endtask

    initial begin
        clk      = 1'b0;
        rstn     = 1'b0;
        in_valid = 1'b0;
        op       = FADD_ADD;
        x        = '0;
        y        = '0;
        in_tag   = '0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        // monitor flags any res_valid here
        repeat (3) @(posedge clk);

        run_far(300);
        wait_drain();
        run_close(150);
        wait_drain();
        run_rounding(100);
        wait_drain();

        if (exp_q.size() == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/fp_pkg.sv
hw/fadd_pkg.sv
hw/lzc.sv
hw/fadd_align.sv
hw/fadd_far_path.sv
hw/fadd_close_path.sv
hw/fadd_round.sv
hw/fpu_add_unit.sv
test/tb_fpu_add_unit.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the FPU adder testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -j 0 --top-module tb_fpu_add_unit -f vlog.f -o sim_fpu_add
status=$?
if [ $status -ne 0 ]; then
    echo "build failed"
    exit 1
fi

output=$(./obj_dir/sim_fpu_add 2>&1)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "Simulation finished: PASS"; then
    exit 0
fi
exit 1
